// File: rtl/eth_test_pkg.sv
//----------------------------------------------------------------------
// shared widths and types for the ethernet link test
// byte-stream beat, status report and report-stream word
//----------------------------------------------------------------------
`default_nettype none

package eth_test_pkg;

    //----------------------------------------------------------------------
    // widths
    //----------------------------------------------------------------------
    // packet size and pause size
    localparam int SIZE_W = 16;
    // frame and bad-frame counters, wrap around
    localparam int CNT_W = 12;
    // port number field of a report
    localparam int PORT_ID_W = 8;

    //----------------------------------------------------------------------
    // types
    //----------------------------------------------------------------------
    // one beat of the per-port byte stream, 11 bits
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       sof;
        logic       eof;
    } eth_beat_t;

    // one status report, 32 bits
    typedef struct packed {
        logic [PORT_ID_W-1:0] port;
        logic [CNT_W-1:0]     frame_cnt;
        logic [CNT_W-1:0]     bad_cnt;
    } report_t;

    // one word of the report stream, 33 bits
    typedef struct packed {
        logic    valid;
        report_t report;
    } aurora_word_t;

endpackage

`default_nettype wire

// File: rtl/test_frame_gen.sv
//----------------------------------------------------------------------
// per-port test frame generator
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module test_frame_gen (
    input  logic                            aurora_usr_clk,
    input  logic                            rst_n_i,
    input  logic                            start_i,
    input  logic [eth_test_pkg::SIZE_W-1:0] pkt_size_i,
    input  logic [eth_test_pkg::SIZE_W-1:0] pause_size_i,
    output eth_test_pkg::eth_beat_t         tx_o
);
    import eth_test_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_FRAME, ST_PAUSE} state_t;

    state_t            state;
    logic [SIZE_W-1:0] byte_cnt;
    logic [SIZE_W-1:0] pause_cnt;
    logic [SIZE_W-1:0] pkt_len;
    logic [SIZE_W-1:0] byte_idx;
    logic [7:0]        seq_cnt;
    logic              emit;
    logic              last_byte;

    // zero size still sends one byte
    assign pkt_len = (pkt_size_i == '0) ? SIZE_W'(1) : pkt_size_i;

    // which byte goes out on this edge, if any
    always_comb begin
        emit = 1'b0;
        byte_idx = '0;
        case (state)
            ST_IDLE:  emit = start_i;
            ST_FRAME: begin
                emit = 1'b1;
                byte_idx = byte_cnt;
            end
            // pause over, next frame only while start held
            ST_PAUSE: emit = start_i && (pause_cnt == '0);
            default:  emit = 1'b0;
        endcase
    end

    assign last_byte = (byte_idx >= pkt_len - 1'b1);

    always_ff @(posedge aurora_usr_clk) begin
        // byte k of frame n is n + k
        tx_o.data <= seq_cnt + byte_idx[7:0];
        if (!rst_n_i) begin
            state <= ST_IDLE;
            byte_cnt <= '0;
            pause_cnt <= '0;
            seq_cnt <= '0;
            tx_o.valid <= 1'b0;
            tx_o.sof <= 1'b0;
            tx_o.eof <= 1'b0;
        end else begin
            tx_o.valid <= emit;
            tx_o.sof <= emit && (byte_idx == '0);
            tx_o.eof <= emit && last_byte;
            if (emit) begin
                if (last_byte) begin
                    state <= ST_PAUSE;
                    byte_cnt <= '0;
                    pause_cnt <= pause_size_i;
                    seq_cnt <= seq_cnt + 8'd1;
                end else begin
                    state <= ST_FRAME;
                    byte_cnt <= byte_idx + 1'b1;
                end
            end else if (state == ST_PAUSE) begin
                if (pause_cnt != '0) begin
                    pause_cnt <= pause_cnt - 1'b1;
                end else begin
                    // start dropped, a later start begins at frame 0
                    state <= ST_IDLE;
                    seq_cnt <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/test_frame_check.sv
//----------------------------------------------------------------------
// per-port receive checker
// frame and bad-frame counters, one coalesced pending report
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module test_frame_check #(
    parameter int PORT_ID = 0
) (
    input  logic                    aurora_usr_clk,
    input  logic                    rst_n_i,
    input  eth_test_pkg::eth_beat_t rx_i,
    output logic                    req_o,
    output eth_test_pkg::report_t   report_o,
    input  logic                    grant_i
);
    import eth_test_pkg::*;

    logic [7:0]       exp_byte;
    logic             bad_flag;
    logic             byte_bad;
    logic             frame_bad;
    logic             frame_end;
    logic [CNT_W-1:0] frame_cnt;
    logic [CNT_W-1:0] bad_cnt;

    //----------------------------------------------------------------------
    // byte check
    //----------------------------------------------------------------------
    // first byte sets the sequence, never wrong on its own
    assign byte_bad = rx_i.valid && !rx_i.sof && (rx_i.data != exp_byte);
    // bad state of the frame including the current byte
    assign frame_bad = rx_i.sof ? 1'b0 : (bad_flag || byte_bad);
    assign frame_end = rx_i.valid && rx_i.eof;

    // expected next byte, first byte + k
    always_ff @(posedge aurora_usr_clk) begin
        if (rx_i.valid) begin
            if (rx_i.sof) begin
                exp_byte <= rx_i.data + 8'd1;
            end else begin
                exp_byte <= exp_byte + 8'd1;
            end
        end
    end

    // sticky bad flag across the frame
    always_ff @(posedge aurora_usr_clk) begin
        if (!rst_n_i) begin
            bad_flag <= 1'b0;
        end else if (rx_i.valid) begin
            bad_flag <= frame_bad;
        end
    end

    //----------------------------------------------------------------------
    // counters and pending report
    //----------------------------------------------------------------------
    always_ff @(posedge aurora_usr_clk) begin
        if (!rst_n_i) begin
            frame_cnt <= '0;
            bad_cnt <= '0;
            req_o <= 1'b0;
        end else begin
            if (frame_end) begin
                frame_cnt <= frame_cnt + 1'b1;
                if (frame_bad) begin
                    bad_cnt <= bad_cnt + 1'b1;
                end
                // newer counts win over a grant on the same edge
                req_o <= 1'b1;
            end else if (grant_i) begin
                req_o <= 1'b0;
            end
        end
    end

    // report always carries the latest cumulative counts
    assign report_o = {PORT_ID_W'(PORT_ID), frame_cnt, bad_cnt};

endmodule

`default_nettype wire

// File: rtl/report_arbiter.sv
//----------------------------------------------------------------------
// round-robin arbiter onto the report stream, credit flow control
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module report_arbiter #(
    parameter int ETH_COUNT = 4,
    parameter int CREDITS   = 4
) (
    input  logic                       aurora_usr_clk,
    input  logic                       rst_n_i,
    input  logic [ETH_COUNT-1:0]       req_i,
    input  eth_test_pkg::report_t      report_i [ETH_COUNT],
    output logic [ETH_COUNT-1:0]       grant_o,
    input  logic                       credit_i,
    output eth_test_pkg::aurora_word_t report_o
);
    import eth_test_pkg::*;

    localparam int PTR_W  = (ETH_COUNT > 1) ? $clog2(ETH_COUNT) : 1;
    localparam int CRED_W = $clog2(CREDITS + 1);
    localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(CREDITS);

    logic [PTR_W-1:0]  last_ptr;
    logic [PTR_W-1:0]  sel_idx;
    logic              found;
    logic              issue;
    logic [CRED_W-1:0] credit_cnt;
    logic [CRED_W:0]   credit_sum;

    //----------------------------------------------------------------------
    // round-robin search, starts after the last granted port
    //----------------------------------------------------------------------
    always_comb begin
        int idx;
        found = 1'b0;
        sel_idx = '0;
        for (int i = 0; i < ETH_COUNT; i++) begin
            idx = int'(last_ptr) + 1 + i;
            if (idx >= ETH_COUNT) begin
                idx = idx - ETH_COUNT;
            end
            if (!found && req_i[idx]) begin
                found = 1'b1;
                sel_idx = PTR_W'(idx);
            end
        end
    end

    // grant only with a credit in hand
    assign issue = found && (credit_cnt != '0);
    assign grant_o = issue ? (ETH_COUNT'(1) << sel_idx) : '0;

    // one credit out per word, one back per credit_i cycle
    assign credit_sum = {1'b0, credit_cnt} + credit_i - issue;

    always_ff @(posedge aurora_usr_clk) begin
        report_o.report <= report_i[sel_idx];
        if (!rst_n_i) begin
            last_ptr <= PTR_W'(ETH_COUNT - 1);
            credit_cnt <= CRED_MAX;
            report_o.valid <= 1'b0;
        end else begin
            report_o.valid <= issue;
            if (issue) begin
                last_ptr <= sel_idx;
            end
            // saturate at the initial credit count
            if (credit_sum > {1'b0, CRED_MAX}) begin
                credit_cnt <= CRED_MAX;
            end else begin
                credit_cnt <= credit_sum[CRED_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/eth_test_top.sv
//----------------------------------------------------------------------
// ethernet link test top level
// per-port generator and checker, shared report arbiter
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module eth_test_top #(
    parameter int ETH_COUNT = 4,
    parameter int CREDITS   = 4
) (
    input  logic                            aurora_usr_clk,
    input  logic                            rst_n_i,
    input  logic [ETH_COUNT-1:0]            start_i,
    input  logic [eth_test_pkg::SIZE_W-1:0] pkt_size_i,
    input  logic [eth_test_pkg::SIZE_W-1:0] pause_size_i,
    output eth_test_pkg::eth_beat_t         tx_o [ETH_COUNT],
    input  eth_test_pkg::eth_beat_t         rx_i [ETH_COUNT],
    output eth_test_pkg::aurora_word_t      report_o,
    input  logic                            credit_i
);
    import eth_test_pkg::*;

    // checker to arbiter
    logic [ETH_COUNT-1:0] peer_req;
    logic [ETH_COUNT-1:0] peer_grant;
    report_t              peer_report [ETH_COUNT];

    //----------------------------------------------------------------------
    // per-port test logic
    //----------------------------------------------------------------------
    for (genvar p = 0; p < ETH_COUNT; p++) begin : g_eth
        test_frame_gen u_gen (
            .aurora_usr_clk (aurora_usr_clk),
            .rst_n_i        (rst_n_i),
            .start_i        (start_i[p]),
            .pkt_size_i     (pkt_size_i),
            .pause_size_i   (pause_size_i),
            .tx_o           (tx_o[p])
        );

        // port number goes into every report
        test_frame_check #(
            .PORT_ID (p)
        ) u_check (
            .aurora_usr_clk (aurora_usr_clk),
            .rst_n_i        (rst_n_i),
            .rx_i           (rx_i[p]),
            .req_o          (peer_req[p]),
            .report_o       (peer_report[p]),
            .grant_i        (peer_grant[p])
        );
    end

    //----------------------------------------------------------------------
    // shared report stream
    //----------------------------------------------------------------------
    report_arbiter #(
        .ETH_COUNT (ETH_COUNT),
        .CREDITS   (CREDITS)
    ) u_arbiter (
        .aurora_usr_clk (aurora_usr_clk),
        .rst_n_i        (rst_n_i),
        .req_i          (peer_req),
        .report_i       (peer_report),
        .grant_o        (peer_grant),
        .credit_i       (credit_i),
        .report_o       (report_o)
    );

endmodule

`default_nettype wire

// File: testbench/report_arbiter_checker.sv
//----------------------------------------------------------------------
// concurrent assertions on the report arbiter
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module report_arbiter_checker #(
    parameter int ETH_COUNT = 4,
    parameter int CREDITS   = 4
) (
    input logic                          aurora_usr_clk,
    input logic                          rst_n_i,
    input logic [ETH_COUNT-1:0]          grant_o,
    input logic [$clog2(CREDITS + 1)-1:0] credit_cnt,
    input eth_test_pkg::aurora_word_t    report_o
);

    // a word on the stream spends a credit held the cycle before
    a_no_word_at_zero: assert property (@(posedge aurora_usr_clk) disable iff (!rst_n_i)
        report_o.valid |-> ($past(credit_cnt) != '0))
        else $error("report word issued with no credit left");

    a_credit_limit: assert property (@(posedge aurora_usr_clk) disable iff (!rst_n_i)
        credit_cnt <= CREDITS)
        else $error("credit count above its maximum");

    // at most one peer per cycle
    a_grant_onehot: assert property (@(posedge aurora_usr_clk) disable iff (!rst_n_i)
        $onehot0(grant_o))
        else $error("more than one grant in a cycle");

endmodule

`default_nettype wire

// File: testbench/eth_test_tb.sv
//----------------------------------------------------------------------
// testbench for the ethernet link test
// loopback with byte flips, tx frame monitor, report compare, watchdog
//----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module eth_test_tb;
    import eth_test_pkg::*;

    localparam int ETH_COUNT = 4;
    localparam int CREDITS = 4;
    localparam int NUM_TESTS = 4;
    // clean with round robin, corrupt, credit hold, restart
    localparam int TEST_FRAMES [NUM_TESTS] = '{6, 10, 8, 5};
    // first test repeats a frame faster than the ports are served, so all stay pending
    localparam int TEST_PKT [NUM_TESTS] = '{2, 12, 6, 5};
    localparam int TEST_PAUSE [NUM_TESTS] = '{1, 0, 2, 4};

    logic                 aurora_usr_clk = 1'b0;
    logic                 rst_n_i;
    logic [ETH_COUNT-1:0] start_i;
    logic [SIZE_W-1:0]    pkt_size_i;
    logic [SIZE_W-1:0]    pause_size_i;
    eth_beat_t            tx_o [ETH_COUNT];
    eth_beat_t            rx_i [ETH_COUNT] = '{default: '0};
    aurora_word_t         report_o;
    logic                 credit_i;

    int      errors;
    string   test_name;
    logic    corrupt_en;
    logic    rr_en;
    logic    hold_active;
    int      rr_prev;
    int      held_words;
    // frames asked for since reset, summed over the tests
    int      exp_frames;
    // loopback state, frames and bad frames sent into rx
    int      lb_idx [ETH_COUNT];
    int      flip_pos [ETH_COUNT];
    logic    flipped [ETH_COUNT];
    int      rx_sent [ETH_COUNT];
    int      rx_bad [ETH_COUNT];
    // rx counts one and two cycles back, lined up with report_o
    int      hist1_sent [ETH_COUNT];
    int      hist1_bad [ETH_COUNT];
    int      hist2_sent [ETH_COUNT];
    int      hist2_bad [ETH_COUNT];
    report_t last_rep [ETH_COUNT] = '{default: '0};
    // tx frame monitor
    int      mon_k [ETH_COUNT];
    int      mon_n [ETH_COUNT];
    int      mon_gap [ETH_COUNT];
    int      mon_sofs [ETH_COUNT];
    int      mon_eofs [ETH_COUNT];
    logic    mon_seen [ETH_COUNT];

    always #20 aurora_usr_clk = ~aurora_usr_clk;

    eth_test_top #(
        .ETH_COUNT (ETH_COUNT),
        .CREDITS   (CREDITS)
    ) u_eth_test_top (
        .aurora_usr_clk (aurora_usr_clk),
        .rst_n_i        (rst_n_i),
        .start_i        (start_i),
        .pkt_size_i     (pkt_size_i),
        .pause_size_i   (pause_size_i),
        .tx_o           (tx_o),
        .rx_i           (rx_i),
        .report_o       (report_o),
        .credit_i       (credit_i)
    );

    bind report_arbiter report_arbiter_checker #(
        .ETH_COUNT (ETH_COUNT),
        .CREDITS   (CREDITS)
    ) u_arbiter_checker (
        .aurora_usr_clk (aurora_usr_clk),
        .rst_n_i        (rst_n_i),
        .grant_o        (grant_o),
        .credit_cnt     (credit_cnt),
        .report_o       (report_o)
    );

    //----------------------------------------------------------------------
    // reference and compare helpers
    //----------------------------------------------------------------------
    // expected report from the frames sent and corrupted, counters wrap
    function automatic report_t ref_report(input int port, input int sent, input int bad);
        report_t r;
        r.port = PORT_ID_W'(port);
        r.frame_cnt = CNT_W'(sent);
        r.bad_cnt = CNT_W'(bad);
        return r;
    endfunction

    function automatic logic all_reached(input int cnt [ETH_COUNT], input int target);
        logic ok;
        ok = 1'b1;
        for (int p = 0; p < ETH_COUNT; p++) begin
            if (cnt[p] < target) ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic check_report(input string name, input report_t expected,
                                input report_t actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s report: expected port %0d frames %0d bad %0d, %s",
                     name, expected.port, expected.frame_cnt, expected.bad_cnt,
                     $sformatf("actual port %0d frames %0d bad %0d",
                               actual.port, actual.frame_cnt, actual.bad_cnt));
        end
    endtask

    task automatic check_beat(input string name, input eth_beat_t expected,
                              input eth_beat_t actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s tx beat: expected data %h sof %b eof %b, %s",
                     name, expected.data, expected.sof, expected.eof,
                     $sformatf("actual data %h valid %b sof %b eof %b",
                               actual.data, actual.valid, actual.sof, actual.eof));
        end
    endtask

    //----------------------------------------------------------------------
    // loopback, tx one cycle later into rx
    //----------------------------------------------------------------------
    always @(posedge aurora_usr_clk) begin
        eth_beat_t beat;
        for (int p = 0; p < ETH_COUNT; p++) begin
            beat = tx_o[p];
            if (beat.valid && beat.sof) begin
                lb_idx[p] = 0;
                flipped[p] = 1'b0;
                flip_pos[p] = 0;
                // about one frame in three, never the first byte
                if (corrupt_en && ($urandom % 3) == 0) begin
                    flip_pos[p] = 1 + int'($urandom % (pkt_size_i - 1));
                end
            end
            if (beat.valid) begin
                if (flip_pos[p] != 0 && lb_idx[p] == flip_pos[p]) begin
                    beat.data = beat.data ^ (8'd1 << ($urandom % 8));
                    flipped[p] = 1'b1;
                end
                if (beat.eof) begin
                    rx_sent[p]++;
                    if (flipped[p]) rx_bad[p]++;
                end
                lb_idx[p]++;
            end
            rx_i[p] <= beat;
        end
    end

    // tx frame format, byte n + k, sof, eof and pause length
    always @(negedge aurora_usr_clk) begin
        eth_beat_t exp_beat;
        for (int p = 0; p < ETH_COUNT; p++) begin
            if (!rst_n_i) begin
                mon_k[p] = 0;
            end else if (tx_o[p].valid) begin
                exp_beat.data = 8'(mon_n[p] + mon_k[p]);
                exp_beat.valid = 1'b1;
                exp_beat.sof = (mon_k[p] == 0);
                exp_beat.eof = (mon_k[p] == int'(pkt_size_i) - 1);
                if (exp_beat.sof && mon_seen[p] && mon_gap[p] != int'(pause_size_i)) begin
                    errors++;
                    $display("MISMATCH %s port %0d idle gap: expected %0d, actual %0d",
                             test_name, p, pause_size_i, mon_gap[p]);
                end
                check_beat($sformatf("%s port %0d", test_name, p), exp_beat, tx_o[p]);
                if (exp_beat.sof) mon_sofs[p]++;
                if (exp_beat.eof) begin
                    mon_k[p] = 0;
                    mon_n[p]++;
                    mon_gap[p] = 0;
                    mon_seen[p] = 1'b1;
                    mon_eofs[p]++;
                end else begin
                    mon_k[p]++;
                end
            end else if (mon_k[p] != 0) begin
                errors++;
                $display("%s port %0d: frame broke off after %0d bytes", test_name, p, mon_k[p]);
                mon_k[p] = 0;
            end else begin
                mon_gap[p]++;
            end
        end
    end

    // every report word against the rx counts two cycles back
    always @(negedge aurora_usr_clk) begin
        int p;
        int exp_p;
        if (rst_n_i && report_o.valid) begin
            p = int'(report_o.report.port);
            // round robin, next port after the previous word
            exp_p = (rr_en && rr_prev >= 0) ? (rr_prev + 1) % ETH_COUNT : p;
            if (p >= ETH_COUNT) begin
                errors++;
                $display("%s: report for port %0d, which does not exist", test_name, p);
            end else begin
                check_report(test_name, ref_report(exp_p, hist2_sent[exp_p], hist2_bad[exp_p]),
                             report_o.report);
                last_rep[p] = report_o.report;
            end
            rr_prev = p;
            if (hold_active) held_words++;
        end
        hist2_sent = hist1_sent;
        hist2_bad = hist1_bad;
        hist1_sent = rx_sent;
        hist1_bad = rx_bad;
    end

    //----------------------------------------------------------------------
    // test sequence
    //----------------------------------------------------------------------
    // until every port has reported all frames looped back
    task automatic drain_reports();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(posedge aurora_usr_clk);
            done = 1'b1;
            for (int p = 0; p < ETH_COUNT; p++) begin
                if (last_rep[p].frame_cnt != CNT_W'(hist1_sent[p])) done = 1'b0;
            end
        end
    endtask

    task automatic run_test(input int t);
        case (t)
            0: test_name = "clean";
            1: test_name = "corrupt";
            2: test_name = "credit";
            default: test_name = "restart";
        endcase
        @(posedge aurora_usr_clk);
        pkt_size_i <= SIZE_W'(TEST_PKT[t]);
        pause_size_i <= SIZE_W'(TEST_PAUSE[t]);
        corrupt_en <= (t == 1);
        credit_i <= (t != 2);
        rr_en = (t == 0);
        rr_prev = -1;
        hold_active = (t == 2);
        held_words = 0;
        // a restart begins again at frame 0
        for (int p = 0; p < ETH_COUNT; p++) begin
            mon_n[p] = 0;
            mon_seen[p] = 1'b0;
            mon_sofs[p] = 0;
            mon_eofs[p] = 0;
        end
        @(posedge aurora_usr_clk);
        start_i <= '1;
        // drop start once the last frame has begun, it still completes
        while (!all_reached(mon_sofs, TEST_FRAMES[t])) @(posedge aurora_usr_clk);
        start_i <= '0;
        while (!all_reached(mon_eofs, TEST_FRAMES[t])) @(posedge aurora_usr_clk);
        if (t == 2) begin
            repeat (ETH_COUNT + 4) @(posedge aurora_usr_clk);
            hold_active = 1'b0;
            if (held_words > CREDITS) begin
                errors++;
                $display("%s: %0d report words went out with credits held, limit is %0d",
                         test_name, held_words, CREDITS);
            end
            credit_i <= 1'b1;
        end
        drain_reports();
        exp_frames += TEST_FRAMES[t];
        for (int p = 0; p < ETH_COUNT; p++) begin
            check_report(test_name, ref_report(p, exp_frames, hist1_bad[p]), last_rep[p]);
        end
        // generators back to idle before the next start
        repeat (TEST_PAUSE[t] + 4) @(posedge aurora_usr_clk);
    endtask

    initial begin
        void'($urandom(32'hbddd_d494));
        errors = 0;
        exp_frames = 0;
        rst_n_i = 1'b0;
        start_i = '0;
        pkt_size_i = SIZE_W'(8);
        pause_size_i = '0;
        credit_i = 1'b1;
        corrupt_en = 1'b0;
        rr_en = 1'b0;
        hold_active = 1'b0;
        repeat (5) @(posedge aurora_usr_clk);
        rst_n_i <= 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // frames x (size + pause + 2) per test, plus reset, drain and settle time
    initial begin
        int budget;
        budget = 5 + NUM_TESTS * 100;
        for (int t = 0; t < NUM_TESTS; t++) begin
            budget += TEST_FRAMES[t] * (TEST_PKT[t] + TEST_PAUSE[t] + 2);
        end
        repeat (budget) @(posedge aurora_usr_clk);
        $display("watchdog timeout after %0d cycles, the run did not finish", budget);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/eth_test_pkg.sv
rtl/test_frame_gen.sv
rtl/test_frame_check.sv
rtl/report_arbiter.sv
rtl/eth_test_top.sv
testbench/report_arbiter_checker.sv
testbench/eth_test_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the ethernet link test with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module eth_test_tb \
    -f project.f -o Veth_test_tb

sim_out=$(./obj_dir/Veth_test_tb 2>&1 || true)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
